// File: axibram_subsys.f
logic/bram_pkg.sv
logic/fifo_same_clock.sv
logic/bram_sdp.sv
logic/bram_arbiter.sv
logic/apb_bram_port.sv
logic/axibram_write.sv
logic/axibram_subsys.sv
tb/tb_axibram_subsys.sv

// File: Makefile
# Verilator build and run for the AXI/APB block RAM subsystem

VERILATOR ?= verilator
TOP       ?= tb_axibram_subsys
FLIST     ?= axibram_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_axibram_subsys.sv
`timescale 1ns/100ps
module tb_axibram_subsys
   import bram_pkg::*;
();

   localparam int ADDRESS_BITS = 10;
   localparam int RAM_WORDS    = 1 << ADDRESS_BITS;
   // preload, then tests 1 to 6, in cycles
   localparam int TEST_CYCLES  = 3 * RAM_WORDS + 30 + 250 + 40 + 80 + 600 + 30;
   localparam int LIMIT_CYCLES = 16 + 4 * TEST_CYCLES;

   logic        aclk;
   logic        rst;
   logic [31:0] awaddr;
   axi_id_t     awid;
   alen_t       awlen;
   logic [1:0]  awsize;
   burst_t      awburst;
   logic        awvalid;
   logic        awready;
   word_t       wdata;
   axi_id_t     wid;
   logic        wlast;
   strb_t       wstrb;
   logic        wvalid;
   logic        wready;
   axi_id_t     bid;
   resp_t       bresp;
   logic        bvalid;
   logic        bready;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] paddr;
   word_t       pwdata;
   strb_t       pstrb;
   word_t       prdata;
   logic        pready;
   logic        pslverr;

   word_t   model [RAM_WORDS];  // expected ram contents
   word_t   wq [$];             // beats waiting to be driven
   strb_t   sq [$];
   axi_id_t exp_bid [$];        // ids of accepted bursts, in order
   int      errors = 0;
   int      mark = 0;           // error count at test start
   int      tests_passed = 0;
   int      tests_failed = 0;
   int      w_held = 0;         // beats sitting in the data fifo
   int      beats_written = 0;
   logic    aw_stalled = 1'b0;
   logic    w_stalled = 1'b0;

   axibram_subsys #(.ADDRESS_BITS(ADDRESS_BITS)) dut_i (.*);

   initial begin
      aclk = 1'b0;
      forever #4 aclk = ~aclk;   // 125 MHz
   end

   initial begin
      #(LIMIT_CYCLES * 8);
      $display("Watchdog expired after %0d cycles, run stopped", LIMIT_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   always @(posedge aclk) begin
      if (rst) begin
         w_held        <= 0;
         beats_written <= 0;
      end else begin
         w_held        <= w_held + int'(wvalid && wready) - int'(dut_i.axi_wen);
         beats_written <= beats_written + int'(dut_i.axi_wen);
      end
   end

   always @(posedge aclk) begin
      if (!rst && bvalid && bready) begin
         assert (exp_bid.size() != 0) else begin
            errors++;
            $display("Write response with bid %h arrived with no burst outstanding", bid);
         end
         if (exp_bid.size() != 0) begin
            assert (bid == exp_bid[0]) else begin
               errors++;
               $display("Error at %0t: bid expected %h got %h", $time, exp_bid[0], bid);
            end
            void'(exp_bid.pop_front());
         end
      end
   end

   always @(negedge aclk) begin
      if (awvalid && !awready) aw_stalled = 1'b1;   // address fifo pushed back
      if (wvalid && !wready) w_stalled = 1'b1;
   end

   a_reset_quiet: assert property (@(posedge aclk) rst |-> !awready && !wready && !pready)
      else begin
         errors++;
         $display("A ready output was high during reset at %0t", $time);
      end
   a_bresp_okay: assert property (@(posedge aclk) disable iff (rst) bvalid |-> bresp == resp_okay)
      else begin
         errors++;
         $display("Error at %0t: bresp expected %h got %h", $time, resp_okay, $sampled(bresp));
      end
   a_w_half: assert property (@(posedge aclk) disable iff (rst) w_held >= 2 |-> !wready)
      else begin
         errors++;
         $display("wready stayed high with the data fifo half full at %0t", $time);
      end
   a_ram_excl: assert property (@(posedge aclk) disable iff (rst)
      dut_i.axi_wen |-> !dut_i.apb_gnt)
      else begin
         errors++;
         $display("AXI write and APB grant shared the ram port at %0t", $time);
      end
   a_slverr_done: assert property (@(posedge aclk) disable iff (rst) pslverr |-> pready)
      else begin
         errors++;
         $display("pslverr raised outside a completing transfer at %0t", $time);
      end

   function automatic word_t fill_word(input int w);
      return 32'h5a3c_0000 ^ (32'(w) * 32'h0001_0021);   // every address bit counts
   endfunction

   function automatic word_t merge(input word_t old, input word_t nw, input strb_t st);
      word_t res;
      res = old;
      for (int lane = 0; lane < 4; lane++) begin
         if (st[lane]) res[lane*8 +: 8] = nw[lane*8 +: 8];
      end
      return res;
   endfunction

   // draw beats for one burst and apply them to the model
   task automatic plan_burst(input int w, input alen_t len, input burst_t bt, input logic mixed);
      int    base;
      int    size;
      word_t d;
      strb_t s;
      size = int'(len) + 1;
      base = w - (w % size);                  // aligned wrap window
      for (int i = 0; i < size; i++) begin
         d = $urandom;
         s = mixed ? strb_t'($urandom) : 4'hf;
         wq.push_back(d);
         sq.push_back(s);
         model[w] = merge(model[w], d, s);
         if (bt == burst_incr) w = (w + 1) % RAM_WORDS;
         else if (bt == burst_wrap) w = base + ((w - base + 1) % size);
      end
   endtask

   task automatic send_aw(input axi_id_t id, input int w, input alen_t len, input burst_t bt);
      @(posedge aclk);
      #1;
      awvalid = 1'b1;
      awid    = id;
      awaddr  = 32'(w) << 2;
      awlen   = len;
      awburst = bt;
      @(negedge aclk);
      while (!awready) @(negedge aclk);
      exp_bid.push_back(id);                  // accepted on the coming edge
      @(posedge aclk);
      #1;
      awvalid = 1'b0;
   endtask

   task automatic send_w(input axi_id_t id, input int n);
      @(posedge aclk);
      #1;
      for (int i = 0; i < n; i++) begin
         wvalid = 1'b1;
         wid    = id;
         wdata  = wq.pop_front();
         wstrb  = sq.pop_front();
         wlast  = (i == n - 1);
         @(negedge aclk);
         while (!wready) @(negedge aclk);
         @(posedge aclk);
         #1;
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
   endtask

   task automatic axi_burst(input axi_id_t id, input int w, input alen_t len, input burst_t bt,
                            input logic mixed, input int aw_delay);
      plan_burst(w, len, bt, mixed);
      fork
         begin
            repeat (aw_delay) @(posedge aclk);   // lets data run ahead of the address
            send_aw(id, w, len, bt);
         end
         send_w(id, int'(len) + 1);
      join
   endtask

   task automatic wait_responses();
      int cycles;
      cycles = 0;
      while (exp_bid.size() != 0 && cycles < 200) begin
         @(posedge aclk);
         cycles++;
      end
      assert (exp_bid.size() == 0) else begin
         errors++;
         $display("%0d write responses still missing after 200 cycles", exp_bid.size());
      end
   endtask

   task automatic wait_written(input int target);
      int cycles;
      cycles = 0;
      while (beats_written < target && cycles < 200) begin
         @(posedge aclk);
         cycles++;
      end
      assert (beats_written >= target) else begin
         errors++;
         $display("Only %0d of %0d beats reached the ram", beats_written, target);
      end
   endtask

   task automatic apb_xfer(input logic wr, input logic [31:0] addr, input word_t wd,
                           input strb_t st, output word_t rd, output logic err);
      int cycles;
      @(posedge aclk);
      #1;
      psel    = 1'b1;                         // setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wd;
      pstrb   = st;
      @(posedge aclk);
      #1;
      penable = 1'b1;
      cycles  = 0;
      @(negedge aclk);
      while (!pready && cycles < 16) begin
         @(negedge aclk);
         cycles++;
      end
      assert (pready) else begin
         errors++;
         $display("APB transfer to %h never got pready", addr);
      end
      rd  = prdata;
      err = pslverr;
      @(posedge aclk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write_word(input int w, input word_t d, input strb_t s);
      word_t rd;
      logic  err;
      apb_xfer(1'b1, 32'(w) << 2, d, s, rd, err);
      model[w] = merge(model[w], d, s);
      assert (!err) else begin
         errors++;
         $display("Error at %0t: pslverr expected 0 got %b", $time, err);
      end
   endtask

   task automatic check_word(input int w);
      word_t rd;
      logic  err;
      apb_xfer(1'b0, 32'(w) << 2, '0, '0, rd, err);
      assert (!err && rd === model[w]) else begin
         errors++;
         $display("Error at %0t: prdata[%h] expected %h got %h (pslverr %b)",
                  $time, w, model[w], rd, err);
      end
   endtask

   task automatic check_range(input int first, input int last);
      for (int w = first; w <= last; w++) check_word(w);
   endtask

   task automatic end_test(input string name);
      if (errors == mark) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - mark);
      end
      mark = errors;
   endtask

   initial begin
      word_t rd;
      logic  err;
      int    a;
      int    target;
      void'($urandom(92));
      rst     = 1'b1;
      awaddr  = '0;
      awid    = '0;
      awlen   = '0;
      awsize  = 2'b10;                        // 32-bit beats only
      awburst = burst_incr;
      awvalid = 1'b0;
      wdata   = '0;
      wid     = '0;
      wlast   = 1'b0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      pstrb   = '0;
      repeat (16) @(posedge aclk);
      #1 rst = 1'b0;
      for (int w = 0; w < RAM_WORDS; w++) apb_write_word(w, fill_word(w), 4'hf);
      mark = errors;

      a = $urandom % RAM_WORDS;
      axi_burst(12'h0a5, a, 4'd0, burst_incr, 1'b0, 0);
      wait_responses();
      check_word(a);
      end_test("1 single beat write");

      axi_burst(12'h010, 'h040, 4'd15, burst_incr, 1'b0, 6);   // data fifo fills first
      axi_burst(12'h011, 'h082, 4'd3, burst_wrap, 1'b0, 0);
      axi_burst(12'h012, 'h0c5, 4'd7, burst_wrap, 1'b0, 0);
      wait_responses();
      check_range('h03f, 'h050);
      check_range('h07f, 'h084);
      check_range('h0bf, 'h0c8);
      end_test("2 incr and wrap bursts");

      axi_burst(12'h020, 'h100, 4'd5, burst_fixed, 1'b1, 0);
      wait_responses();
      check_range('h0ff, 'h101);
      end_test("3 fixed burst strobes");

      bready = 1'b0;
      target = beats_written + 9;
      plan_burst('h140, 4'd2, burst_incr, 1'b0);
      plan_burst('h150, 4'd2, burst_incr, 1'b0);
      plan_burst('h160, 4'd2, burst_incr, 1'b0);
      fork
         begin
            send_aw(12'h111, 'h140, 4'd2, burst_incr);
            send_aw(12'h222, 'h150, 4'd2, burst_incr);
            send_aw(12'h333, 'h160, 4'd2, burst_incr);
         end
         begin
            repeat (8) @(posedge aclk);       // address fifo fills meanwhile
            send_w(12'h111, 3);
            send_w(12'h222, 3);
            send_w(12'h333, 3);
         end
      join
      wait_written(target);
      repeat (4) @(posedge aclk);
      assert (bvalid && exp_bid.size() == 3) else begin
         errors++;
         $display("Three responses were not held back while bready was low");
      end
      #1 bready = 1'b1;
      wait_responses();
      assert (aw_stalled && w_stalled) else begin
         errors++;
         $display("awready or wready never dropped on a half full fifo");
      end
      check_range('h140, 'h142);
      check_range('h150, 'h152);
      check_range('h160, 'h162);
      end_test("4 response back-pressure");

      fork
         axi_burst(12'h5c3, 'h180, 4'd15, burst_incr, 1'b1, 2);
         for (int k = 0; k < 24; k++) begin
            a = 'h200 + ($urandom % 64);
            if ($urandom % 2) apb_write_word(a, $urandom, strb_t'($urandom));
            else check_word(a);
         end
      join
      wait_responses();
      check_range('h17f, 'h190);
      check_range('h200, 'h23f);
      end_test("5 apb and axi interleaved");

      apb_xfer(1'b1, 32'h0000_1080, 32'hdead_beef, 4'hf, rd, err);   // aliases word 0x20
      assert (err) else begin
         errors++;
         $display("Error at %0t: pslverr expected 1 got %b", $time, err);
      end
      apb_xfer(1'b0, 32'h8000_0080, '0, '0, rd, err);
      assert (err) else begin
         errors++;
         $display("Error at %0t: pslverr expected 1 got %b", $time, err);
      end
      check_word('h020);
      end_test("6 out of range apb");

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: logic/axibram_subsys.sv
`timescale 1ns/100ps
module axibram_subsys
   import bram_pkg::*;
#(
   parameter ADDRESS_BITS = 10                 // 4 KB of ram by default
) (
   input  logic        aclk,
   input  logic        rst,
   input  logic [31:0] awaddr,
   input  axi_id_t     awid,
   input  alen_t       awlen,
   input  logic [1:0]  awsize,
   input  burst_t      awburst,
   input  logic        awvalid,
   output logic        awready,
   input  word_t       wdata,
   input  axi_id_t     wid,
   input  logic        wlast,
   input  strb_t       wstrb,
   input  logic        wvalid,
   output logic        wready,
   output axi_id_t     bid,
   output resp_t       bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  word_t       pwdata,
   input  strb_t       pstrb,
   output word_t       prdata,
   output logic        pready,
   output logic        pslverr
);

   logic                    apb_req;
   logic                    apb_we;
   logic [ADDRESS_BITS-1:0] apb_addr;
   word_t                   apb_wdata;
   strb_t                   apb_strb;
   logic                    apb_gnt;
   logic                    axi_wen;
   logic [ADDRESS_BITS-1:0] axi_waddr;
   word_t                   axi_wdata;
   strb_t                   axi_wstrb;
   logic                    dev_ready;
   logic                    ram_en;
   logic                    ram_we;
   logic [ADDRESS_BITS-1:0] ram_addr;
   word_t                   ram_wdata;
   strb_t                   ram_strb;
   word_t                   ram_rdata;

   axibram_write #(.ADDRESS_BITS(ADDRESS_BITS)) axi_wr_i (
      .aclk(aclk), .rst(rst),
      .awaddr(awaddr), .awid(awid), .awlen(awlen), .awsize(awsize), .awburst(awburst),
      .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wid(wid), .wlast(wlast), .wstrb(wstrb),
      .wvalid(wvalid), .wready(wready),
      .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .dev_ready(dev_ready),
      .axi_wen(axi_wen), .axi_waddr(axi_waddr), .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb)
   );

   apb_bram_port #(.ADDRESS_BITS(ADDRESS_BITS)) apb_i (
      .aclk(aclk), .rst(rst),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .apb_req(apb_req), .apb_we(apb_we), .apb_addr(apb_addr),
      .apb_wdata(apb_wdata), .apb_strb(apb_strb),
      .apb_gnt(apb_gnt), .ram_rdata(ram_rdata)
   );

   bram_arbiter #(.ADDRESS_BITS(ADDRESS_BITS)) arb_i (
      .aclk(aclk), .rst(rst),
      .apb_req(apb_req), .apb_we(apb_we), .apb_addr(apb_addr),
      .apb_wdata(apb_wdata), .apb_strb(apb_strb), .apb_gnt(apb_gnt),
      .axi_wen(axi_wen), .axi_waddr(axi_waddr), .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb),
      .dev_ready(dev_ready),
      .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
      .ram_wdata(ram_wdata), .ram_strb(ram_strb)
   );

   bram_sdp #(.ADDRESS_BITS(ADDRESS_BITS)) ram_i (
      .aclk(aclk),
      .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
      .ram_wdata(ram_wdata), .ram_strb(ram_strb), .ram_rdata(ram_rdata)
   );

endmodule

// File: logic/axibram_write.sv
`timescale 1ns/100ps
module axibram_write
   import bram_pkg::*;
#(
   parameter ADDRESS_BITS = 10                 // ram word address bits
) (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic [31:0]             awaddr,     // byte address
   input  axi_id_t                 awid,
   input  alen_t                   awlen,
   input  logic [1:0]              awsize,     // 2 only for 32-bit beats
   input  burst_t                  awburst,
   input  logic                    awvalid,
   output logic                    awready,
   input  word_t                   wdata,
   input  axi_id_t                 wid,
   input  logic                    wlast,
   input  strb_t                   wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output axi_id_t                 bid,
   output resp_t                   bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  logic                    dev_ready,  // ram port free per arbiter
   output logic                    axi_wen,
   output logic [ADDRESS_BITS-1:0] axi_waddr,
   output word_t                   axi_wdata,
   output strb_t                   axi_wstrb
);

   logic                    aw_nempty;
   logic                    aw_half_full;
   axi_id_t                 awid_out;
   burst_t                  awburst_out;
   logic [1:0]              awsize_out;
   alen_t                   awlen_out;
   logic [ADDRESS_BITS-1:0] awaddr_out;    // start word address
   logic                    w_nempty;
   logic                    w_half_full;
   axi_id_t                 wid_out;
   logic                    wlast_out;
   strb_t                   wstrb_out;
   word_t                   wdata_out;

   logic                    ports_on;      // holds off awready/wready in reset
   logic                    dev_ready_r;   // registered device ready
   logic                    dev_ok;
   logic                    in_progress;   // burst active
   burst_t                  wburst;        // latched burst type
   alen_t                   wlen;          // latched length, wrap window
   alen_t                   write_left;    // beats left after current
   logic [ADDRESS_BITS-1:0] write_addr;
   logic [ADDRESS_BITS-1:0] next_addr;
   logic [ADDRESS_BITS-1:0] wrap_mask;
   logic                    last_beat;
   logic                    start_burst;

   assign awready = ports_on & ~aw_half_full;
   assign wready  = ports_on & ~w_half_full;

   // registered copy plus live ready keeps writes off apb cycles
   assign dev_ok      = dev_ready_r & dev_ready;
   assign axi_wen     = w_nempty & in_progress & dev_ok;
   assign last_beat   = (write_left == '0) | wlast_out;  // count or wlast ends it
   assign start_burst = aw_nempty & w_nempty & dev_ok & (~in_progress | last_beat);

   assign axi_waddr = write_addr;
   assign axi_wdata = wdata_out;
   assign axi_wstrb = wstrb_out;

   assign wrap_mask = ADDRESS_BITS'(wlen);  // len 1/3/7/15 -> window of 2/4/8/16

   always_comb begin
      case (wburst)
         burst_fixed: next_addr = write_addr;                 // same word every beat
         burst_wrap:  next_addr = (write_addr & ~wrap_mask) |
                                  ((write_addr + 1'b1) & wrap_mask); // stay in window
         default:     next_addr = write_addr + 1'b1;          // incr
      endcase
   end

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) begin
         ports_on    <= 1'b0;
         dev_ready_r <= 1'b0;
         in_progress <= 1'b0;
         wburst      <= burst_incr;
         wlen        <= '0;
         write_left  <= '0;
         write_addr  <= '0;
      end else begin
         ports_on    <= 1'b1;
         dev_ready_r <= dev_ready;
         if (start_burst) in_progress <= 1'b1;              // wins over the end
         else if (axi_wen && last_beat) in_progress <= 1'b0;
         if (start_burst) begin
            wburst     <= awburst_out;
            wlen       <= awlen_out;
            write_left <= awlen_out;
            write_addr <= awaddr_out;
         end else if (axi_wen) begin
            write_left <= write_left - 1'b1;
            write_addr <= next_addr;
         end
      end
   end

   fifo_same_clock #(.DATA_WIDTH(20 + ADDRESS_BITS), .DATA_DEPTH(4)) waddr_i (
      .aclk      (aclk),
      .rst       (rst),
      .we        (awvalid & awready),
      .re        (start_burst),
      .data_in   ({awid, awburst, awsize, awlen, awaddr[ADDRESS_BITS+1:2]}),
      .data_out  ({awid_out, awburst_out, awsize_out, awlen_out, awaddr_out}),
      .nempty    (aw_nempty),
      .half_full (aw_half_full)
   );

   fifo_same_clock #(.DATA_WIDTH(49), .DATA_DEPTH(4)) wdata_i (
      .aclk      (aclk),
      .rst       (rst),
      .we        (wvalid & wready),
      .re        (axi_wen),                    // one pop per ram write
      .data_in   ({wid, wlast, wstrb, wdata}),
      .data_out  ({wid_out, wlast_out, wstrb_out, wdata_out}),
      .nempty    (w_nempty),
      .half_full (w_half_full)
   );

   fifo_same_clock #(.DATA_WIDTH(14), .DATA_DEPTH(4)) wresp_i (
      .aclk      (aclk),
      .rst       (rst),
      .we        (axi_wen & last_beat),        // final beat -> response
      .re        (bvalid & bready),
      .data_in   ({wid_out, resp_okay}),
      .data_out  ({bid, bresp}),
      .nempty    (bvalid),
      .half_full ()
   );

   // wlast comes with the final beat by count
   a_wlast_match: assert property (@(posedge aclk) disable iff (rst)
      axi_wen |-> wlast_out == (write_left == '0));
   // head of both fifos belongs to the same burst when starting from idle
   a_burst_head: assert property (@(posedge aclk) disable iff (rst)
      start_burst |-> (awsize_out == 2'b10) && (in_progress || (awid_out == wid_out)));

endmodule

// File: logic/apb_bram_port.sv
`timescale 1ns/100ps
module apb_bram_port
   import bram_pkg::*;
#(
   parameter ADDRESS_BITS = 10
) (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [31:0]             paddr,      // byte address
   input  word_t                   pwdata,
   input  strb_t                   pstrb,
   output word_t                   prdata,
   output logic                    pready,
   output logic                    pslverr,
   output logic                    apb_req,
   output logic                    apb_we,
   output logic [ADDRESS_BITS-1:0] apb_addr,
   output word_t                   apb_wdata,
   output strb_t                   apb_strb,
   input  logic                    apb_gnt,
   input  word_t                   ram_rdata
);

   typedef enum logic [1:0] {st_idle, st_read_wait, st_done} apb_state_t;

   apb_state_t state;
   apb_state_t state_nxt;
   logic       access;      // access phase
   logic       in_range;
   logic       idle_done;   // write or error finishing in first access cycle

   assign access    = psel & penable;
   assign in_range  = ~|paddr[31:ADDRESS_BITS+2];  // bits above the ram must be 0
   assign idle_done = access & (state == st_idle) & (~in_range | (pwrite & apb_gnt));

   assign apb_req   = access & in_range & (state == st_idle);
   assign apb_we    = pwrite;
   assign apb_addr  = paddr[ADDRESS_BITS+1:2];      // word address
   assign apb_wdata = pwdata;
   assign apb_strb  = pstrb;

   assign pready  = idle_done | (state == st_read_wait);  // read has one wait state
   assign pslverr = access & (state == st_idle) & ~in_range;
   assign prdata  = ram_rdata;                            // held until next ram read

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (idle_done) state_nxt = st_done;
            else if (access && apb_gnt) state_nxt = st_read_wait;  // ram read issued
         end
         st_read_wait: state_nxt = st_done;
         st_done: begin
            if (!penable) state_nxt = st_idle;    // transfer closed by master
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) state <= st_idle;
      else     state <= state_nxt;
   end

   // granted read completes exactly one cycle later, without error
   a_read_latency: assert property (@(posedge aclk) disable iff (rst)
      apb_gnt && !apb_we |=> pready && !pslverr);

endmodule

// File: logic/bram_arbiter.sv
`timescale 1ns/100ps
module bram_arbiter
   import bram_pkg::*;
#(
   parameter ADDRESS_BITS = 10
) (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic                    apb_req,
   input  logic                    apb_we,
   input  logic [ADDRESS_BITS-1:0] apb_addr,
   input  word_t                   apb_wdata,
   input  strb_t                   apb_strb,
   output logic                    apb_gnt,
   input  logic                    axi_wen,
   input  logic [ADDRESS_BITS-1:0] axi_waddr,
   input  word_t                   axi_wdata,
   input  strb_t                   axi_wstrb,
   output logic                    dev_ready,  // to axi side, registered there
   output logic                    ram_en,
   output logic                    ram_we,
   output logic [ADDRESS_BITS-1:0] ram_addr,
   output word_t                   ram_wdata,
   output strb_t                   ram_strb
);

   logic apb_owned_q;   // apb held the port last cycle

   // fixed priority, apb always wins
   assign apb_gnt   = apb_req;
   assign dev_ready = ~apb_req;

   assign ram_en    = apb_gnt | axi_wen;
   assign ram_we    = apb_gnt ? apb_we    : axi_wen;
   assign ram_addr  = apb_gnt ? apb_addr  : axi_waddr;
   assign ram_wdata = apb_gnt ? apb_wdata : axi_wdata;
   assign ram_strb  = apb_gnt ? apb_strb  : axi_wstrb;

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) apb_owned_q <= 1'b0;
      else     apb_owned_q <= apb_gnt;
   end

   // axi write never shares a cycle with an apb grant, nor follows one directly
   a_grant_excl: assert property (@(posedge aclk) disable iff (rst)
      axi_wen |-> !apb_gnt && !apb_owned_q);

endmodule

// File: logic/bram_sdp.sv
`timescale 1ns/100ps
module bram_sdp
   import bram_pkg::*;
#(
   parameter ADDRESS_BITS = 10
) (
   input  logic                    aclk,
   input  logic                    ram_en,
   input  logic                    ram_we,
   input  logic [ADDRESS_BITS-1:0] ram_addr,
   input  word_t                   ram_wdata,
   input  strb_t                   ram_strb,    // per byte lane
   output word_t                   ram_rdata    // one cycle after enabled read
);

   word_t mem [2**ADDRESS_BITS];

   always_ff @(posedge aclk) begin
      if (ram_en) begin
         if (ram_we) begin
            for (int lane = 0; lane < 4; lane++) begin
               if (ram_strb[lane]) mem[ram_addr][lane*8 +: 8] <= ram_wdata[lane*8 +: 8];
            end
         end else begin
            ram_rdata <= mem[ram_addr];            // rdata unchanged on writes
         end
      end
   end

endmodule

// File: logic/fifo_same_clock.sv
`timescale 1ns/100ps
module fifo_same_clock #(
   parameter DATA_WIDTH = 16,                  // entry width
   parameter DATA_DEPTH = 4                    // entries, power of two
) (
   input  logic                  aclk,
   input  logic                  rst,
   input  logic                  we,          // push data_in
   input  logic                  re,          // pop head
   input  logic [DATA_WIDTH-1:0] data_in,
   output logic [DATA_WIDTH-1:0] data_out,    // head entry, fall-through
   output logic                  nempty,
   output logic                  half_full
);

   localparam PTR_BITS = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
   localparam CNT_BITS = $clog2(DATA_DEPTH + 1);

   logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];   // storage
   logic [PTR_BITS-1:0]   wr_ptr;
   logic [PTR_BITS-1:0]   rd_ptr;
   logic [CNT_BITS-1:0]   count;              // entries held

   assign data_out  = mem[rd_ptr];
   assign nempty    = (count != '0);
   assign half_full = (count >= CNT_BITS'(DATA_DEPTH / 2)); // ready drops here

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (we) wr_ptr <= wr_ptr + 1'b1;     // wraps at depth
         if (re) rd_ptr <= rd_ptr + 1'b1;
         case ({we, re})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // both or neither
         endcase
      end
   end

   always_ff @(posedge aclk) begin
      if (we) mem[wr_ptr] <= data_in;
   end

   // a push into a full fifo drops the entry, a pop from an empty one repeats junk
   a_no_overflow: assert property (@(posedge aclk) disable iff (rst)
      we && !re |-> count != CNT_BITS'(DATA_DEPTH));
   a_no_underflow: assert property (@(posedge aclk) disable iff (rst)
      re |-> nempty);

endmodule

// File: logic/bram_pkg.sv
package bram_pkg;

   typedef logic [31:0] word_t;       // ram and bus data word
   typedef logic [3:0]  strb_t;       // one bit per byte lane
   typedef logic [11:0] axi_id_t;     // awid / wid / bid
   typedef logic [1:0]  burst_t;      // awburst
   typedef logic [3:0]  alen_t;       // axi3 beats minus one
   typedef logic [1:0]  resp_t;       // bresp

   // axi burst types
   localparam burst_t burst_fixed = 2'b00;
   localparam burst_t burst_incr  = 2'b01;
   localparam burst_t burst_wrap  = 2'b10;

   // axi write responses
   localparam resp_t resp_okay   = 2'b00;
   localparam resp_t resp_exokay = 2'b01;
   localparam resp_t resp_slverr = 2'b10;
   localparam resp_t resp_decerr = 2'b11;

endpackage
